// ==== decode_testdata.txt ====
# stimulus line: name instr pc rnd rs1 rs2 tail ctrl  (ctrl: dd id pc_en halt flush sfd sex)
# expect line: strobes alu rd f3 rob exflags, sel/value for a b wdata jbase joff imm sdata
add_rr 002081b3 00000100 1 00000000 00000000 1 10
1b 0 03 0 1 01 1 00000000 2 00000000 0 00000000 1 00000000 0 00000002 3 00000000 0 00000000
sub_rr 407302b3 00000100 1 00000000 00000000 2 10
1b 1 05 0 2 01 1 00000000 2 00000000 0 00000000 1 00000000 0 00000407 3 00000000 0 00000000
srai 4050d213 00000100 1 00000000 00000000 3 10
1b 7 04 5 3 01 1 00000000 0 00000005 0 00000000 1 00000000 3 00000000 3 00000000 0 00000000
addi_neg fff08113 00000100 1 00000000 00000000 4 10
1b 0 02 0 4 01 1 00000000 0 ffffffff 0 00000000 1 00000000 0 ffffffff 3 00000000 0 00000000
lui 123450b7 00000100 0 00000000 00000000 5 10
1b 0 01 5 5 01 0 00000000 0 12345000 0 12345000 0 00000000 3 00000000 3 00000000 0 00000000
auipc 00001117 00000100 0 00000000 00000000 6 10
1b 0 02 1 6 01 0 00000100 0 00001000 0 00000000 0 00000100 3 00000000 3 00000000 0 00000000
jal 008000ef 00000100 0 00000000 00000000 7 10
1b 0 01 0 7 41 3 00000000 3 00000000 0 00000104 0 00000100 0 00000008 3 00000000 0 00000000
jalr 00c280e7 00000100 1 00000000 00000000 8 10
1b 0 01 0 8 41 1 00000000 3 00000000 0 00000104 1 00000000 0 0000000c 3 00000000 0 00000000
blt 0020c863 00000100 1 00000000 00000000 9 10
1a 1 10 4 9 80 1 00000000 2 00000000 0 00000000 1 00000000 3 00000000 0 00000010 0 00000000
lw 0080a303 00000100 1 00000000 00000000 a 10
1b 0 06 2 a 07 1 00000000 0 00000008 0 00000000 1 00000000 0 00000008 3 00000000 2 00000000
sw 0020a623 00000100 0 11111111 22222222 b 10
1a 0 0c 2 b 0a 0 0000000c 0 11111111 0 00000000 0 0000000c 0 00000002 0 0000000c 0 22222222
hold1 002081b3 00000100 0 00000000 00000000 c 11
1b 0 0c 2 b 0a 0 0000000c 0 11111111 0 00000000 0 0000000c 0 00000002 0 0000000c 0 22222222
hold2 002081b3 00000100 0 00000000 00000000 d 11
1b 0 0c 2 b 0a 0 0000000c 0 11111111 0 00000000 0 0000000c 0 00000002 0 0000000c 0 22222222
bubble 002081b3 00000100 0 00000000 00000000 d 12
19 0 00 0 0 00 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000
add_again 002081b3 00000100 1 00000000 00000000 e 10
1b 0 03 0 e 01 1 00000000 2 00000000 0 00000000 1 00000000 0 00000002 3 00000000 0 00000000
flush 002081b3 00000100 0 00000000 00000000 e 14
1b 0 00 0 0 00 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000
addi_fix fff08113 00000100 0 0000abcd 00000000 f 10
1b 0 02 0 f 01 0 0000abcd 0 ffffffff 0 00000000 0 0000abcd 0 ffffffff 3 00000000 0 00000000
both_stall 123450b7 00000100 0 00000000 00000000 1 13
19 0 02 0 f 01 0 0000abcd 0 ffffffff 0 00000000 0 0000abcd 0 ffffffff 3 00000000 0 00000000
halt_in 002081b3 00000100 0 00000000 00000000 2 18
1b 0 00 0 0 00 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000
fence1 0000100f 00000100 0 00000000 00000000 1 10
1c 0 00 1 1 00 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000
fence2 0000100f 00000100 0 00000000 00000000 2 10
00 0 00 1 2 00 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000
idone 00000013 00000100 0 00000000 00000000 3 30
03 0 00 0 3 01 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000
dnopc 00000013 00000100 0 00000000 00000000 4 40
0b 0 00 0 4 01 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000
ddone 00000013 00000100 0 00000000 00000000 5 50
0b 0 00 0 5 01 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000
clean 00000013 00000100 0 00000000 00000000 6 10
1b 0 00 0 6 01 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000
halt_ins ffffffff 00000100 0 00000000 00000000 7 10
1a 0 1f 7 7 20 0 00000000 0 00000000 0 00000000 0 00000000 0 ffffffff 0 fffffffe 0 00000000
illegal 0000007b 00000100 0 00000000 00000000 8 10
1a 0 00 0 8 10 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000 0 00000000

// ==== filelist.f ====
decode_pkg.sv
control_unit.sv
imm_gen.sv
operand_select.sv
fence_unit.sv
decode_execute_latch.sv
decode_stage.sv
tb_decode_stage.sv

// ==== Makefile ====
TOP = tb_decode_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f filelist.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_decode_stage.sv ====
`default_nettype none

module tb_decode_stage import decode_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_VEC = 40;

  logic CLK, nRST, halt, stall_ex, stall_fetch_decode, decode_execute_flush;
  logic pc_en, iflush_done, dflush_done;
  word_t instr, pc, pc4, rs1_data, rs2_data;
  logic [ROB_IDX_W-1:0] cur_tail;
  reg_idx_t rs1, rs2, rd_decode, ex_rd;
  logic rf_rden, alloc_ena, icache_flush, dcache_flush, iflushed, dflushed;
  fu_type_t ex_fu_type;
  alu_op_t ex_alu_op;
  word_t ex_port_a, ex_port_b, ex_pc, ex_pc4, ex_immediate, ex_wdata;
  word_t ex_j_base, ex_j_offset, ex_store_data;
  logic ex_wen, ex_jump_instr, ex_branch_instr, ex_dren, ex_dwen, ex_illegal, ex_halt;
  branch_type_t ex_branch_type;
  load_type_t ex_load_type;
  logic [ROB_IDX_W-1:0] ex_rob_index;

  // vectors from the data file
  string names[MAX_VEC];
  word_t instr_v[MAX_VEC], pc_v[MAX_VEC], rs1_v[MAX_VEC], rs2_v[MAX_VEC];
  int rnd_v[MAX_VEC], tail_v[MAX_VEC], ctrl_v[MAX_VEC], cflag_v[MAX_VEC];
  int alu_v[MAX_VEC], rd_v[MAX_VEC], f3_v[MAX_VEC], rob_v[MAX_VEC], xflag_v[MAX_VEC];
  int w_sel[MAX_VEC][7];
  word_t w_val[MAX_VEC][7];
  // latched pc fields expected after each vector
  word_t ex_pc_v[MAX_VEC], ex_pc4_v[MAX_VEC];
  int fails_v[MAX_VEC];
  int nvec = 0;
  int cycles = 0;
  int limit = 100000;

  decode_stage #(.ROB_IDX_W(ROB_IDX_W)) uut (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // rv32i register fields sit at bits 11:7, 19:15 and 24:20
  function automatic int reg_field(input word_t word, input int lsb);
    return int'((word >> lsb) & 32'h1f);
  endfunction

  task automatic check_value(input int k, input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s: %s expected %h actual %h", names[k], field, exp, act);
      fails_v[k]++;
    end
  endtask

  // sel 0 literal, 1 rs1 data, 2 rs2 data, 3 not checked
  task automatic check_word(input int k, input string field, input int idx,
                            input word_t act);
    word_t exp;
    if (w_sel[k][idx] == 3) return;
    case (w_sel[k][idx])
      1:       exp = rs1_v[k];
      2:       exp = rs2_v[k];
      default: exp = w_val[k][idx];
    endcase
    check_value(k, field, exp, act);
  endtask

  task automatic apply_vector(input int k);
    word_t held_pc;
    word_t held_pc4;
    held_pc = (k > 0) ? ex_pc_v[k-1] : '0;
    held_pc4 = (k > 0) ? ex_pc4_v[k-1] : '0;
    if (rnd_v[k] != 0) begin
      rs1_v[k] = $urandom;
      rs2_v[k] = $urandom;
    end
    instr = instr_v[k];
    pc = pc_v[k];
    pc4 = pc_v[k] + 32'd4;
    rs1_data = rs1_v[k];
    rs2_data = rs2_v[k];
    cur_tail = tail_v[k][ROB_IDX_W-1:0];
    stall_ex = ctrl_v[k][0];
    stall_fetch_decode = ctrl_v[k][1];
    decode_execute_flush = ctrl_v[k][2];
    halt = ctrl_v[k][3];
    pc_en = ctrl_v[k][4];
    iflush_done = ctrl_v[k][5];
    dflush_done = ctrl_v[k][6];
    // clear wins over hold, hold wins over capture
    if (ctrl_v[k][2] || (ctrl_v[k][1] && !ctrl_v[k][0]) || ctrl_v[k][3]) begin
      ex_pc_v[k] = '0;
      ex_pc4_v[k] = '0;
    end else if (ctrl_v[k][0]) begin
      ex_pc_v[k] = held_pc;
      ex_pc4_v[k] = held_pc4;
    end else begin
      ex_pc_v[k] = pc_v[k];
      ex_pc4_v[k] = pc_v[k] + 32'd4;
    end
  endtask

  task automatic check_comb(input int k);
    check_value(k, "strobes", 32'(cflag_v[k]),
                32'({dflushed, iflushed, icache_flush, alloc_ena, rf_rden}));
    check_value(k, "dcache_flush", 32'((cflag_v[k] >> 2) & 1), 32'(dcache_flush));
    check_value(k, "rs1", 32'(reg_field(instr_v[k], 15)), 32'(rs1));
    check_value(k, "rs2", 32'(reg_field(instr_v[k], 20)), 32'(rs2));
    check_value(k, "rd_decode", 32'(reg_field(instr_v[k], 7)), 32'(rd_decode));
  endtask

  task automatic check_latch(input int k);
    check_value(k, "ex_alu_op", 32'(alu_v[k]), 32'(ex_alu_op));
    check_value(k, "ex_rd", 32'(rd_v[k]), 32'(ex_rd));
    check_value(k, "ex_branch_type", 32'(f3_v[k]), 32'(ex_branch_type));
    check_value(k, "ex_load_type", 32'(f3_v[k]), 32'(ex_load_type));
    check_value(k, "ex_rob_index", 32'(rob_v[k]), 32'(ex_rob_index));
    check_value(k, "ex flags", 32'(xflag_v[k]), 32'({ex_branch_instr, ex_jump_instr,
                ex_halt, ex_illegal, ex_dwen, ex_dren, ex_fu_type, ex_wen}));
    check_value(k, "ex_pc", ex_pc_v[k], ex_pc);
    check_value(k, "ex_pc4", ex_pc4_v[k], ex_pc4);
    check_word(k, "ex_port_a", 0, ex_port_a);
    check_word(k, "ex_port_b", 1, ex_port_b);
    check_word(k, "ex_wdata", 2, ex_wdata);
    check_word(k, "ex_j_base", 3, ex_j_base);
    check_word(k, "ex_j_offset", 4, ex_j_offset);
    check_word(k, "ex_immediate", 5, ex_immediate);
    check_word(k, "ex_store_data", 6, ex_store_data);
  endtask

  initial begin
    int fd;
    int r;
    int failed;
    logic stim_next;
    string line;
    {halt, stall_ex, stall_fetch_decode, decode_execute_flush} = '0;
    {pc_en, iflush_done, dflush_done} = '0;
    {instr, pc, pc4, rs1_data, rs2_data} = '0;
    cur_tail = '0;
    nRST = 1'b0;
    failed = 0;
    stim_next = 1'b1;
    r = $urandom(32'hff6e4466);
    fd = $fopen("decode_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open decode_testdata.txt");
    end
    while (fd != 0 && !$feof(fd)) begin
      r = $fgets(line, fd);
      if (r == 0) break;
      if (line.len() < 4 || line[0] == "#") continue;
      if (stim_next) begin
        r = $sscanf(line, "%s %h %h %h %h %h %h %h", names[nvec], instr_v[nvec], pc_v[nvec],
                    rnd_v[nvec], rs1_v[nvec], rs2_v[nvec], tail_v[nvec], ctrl_v[nvec]);
      end else begin
        r = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    cflag_v[nvec], alu_v[nvec], rd_v[nvec], f3_v[nvec], rob_v[nvec],
                    xflag_v[nvec], w_sel[nvec][0], w_val[nvec][0], w_sel[nvec][1],
                    w_val[nvec][1], w_sel[nvec][2], w_val[nvec][2], w_sel[nvec][3],
                    w_val[nvec][3], w_sel[nvec][4], w_val[nvec][4], w_sel[nvec][5],
                    w_val[nvec][5], w_sel[nvec][6], w_val[nvec][6]);
        fails_v[nvec] = 0;
        nvec++;
      end
      stim_next = ~stim_next;
    end
    // one cycle per vector plus the reset
    limit = 4 * (nvec + 1) + 16;
    repeat (16) @(negedge CLK);
    nRST = 1'b1;
    for (int k = 0; k <= nvec; k++) begin
      @(negedge CLK);
      if (k > 0) begin
        check_latch(k - 1);
        if (fails_v[k-1] == 0) begin
          $display("%-12s ok", names[k-1]);
        end else begin
          $display("%-12s FAILED with %0d errors", names[k-1], fails_v[k-1]);
          failed++;
        end
      end
      if (k < nvec) begin
        apply_vector(k);
        #1;
        check_comb(k);
      end
    end
    $display("tests run %0d, tests failed %0d", nvec, failed);
    if (failed == 0 && nvec > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`default_nettype none

module decode_stage import decode_pkg::*; #(
  parameter int ROB_IDX_W = decode_pkg::ROB_IDX_W
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 halt,
  input  word_t                instr,
  input  word_t                pc,
  input  word_t                pc4,
  input  word_t                rs1_data,
  input  word_t                rs2_data,
  input  logic [ROB_IDX_W-1:0] cur_tail,
  input  logic                 stall_ex,
  input  logic                 stall_fetch_decode,
  input  logic                 decode_execute_flush,
  input  logic                 pc_en,
  input  logic                 iflush_done,
  input  logic                 dflush_done,
  output reg_idx_t             rs1,
  output reg_idx_t             rs2,
  output reg_idx_t             rd_decode,
  output logic                 rf_rden,
  output logic                 alloc_ena,
  output logic                 icache_flush,
  output logic                 dcache_flush,
  output logic                 iflushed,
  output logic                 dflushed,
  output fu_type_t             ex_fu_type,
  output alu_op_t              ex_alu_op,
  output word_t                ex_port_a,
  output word_t                ex_port_b,
  output word_t                ex_pc,
  output word_t                ex_pc4,
  output word_t                ex_immediate,
  output word_t                ex_wdata,
  output reg_idx_t             ex_rd,
  output logic                 ex_wen,
  output logic                 ex_jump_instr,
  output word_t                ex_j_base,
  output word_t                ex_j_offset,
  output logic                 ex_branch_instr,
  output branch_type_t         ex_branch_type,
  output logic                 ex_dren,
  output logic                 ex_dwen,
  output load_type_t           ex_load_type,
  output word_t                ex_store_data,
  output logic [ROB_IDX_W-1:0] ex_rob_index,
  output logic                 ex_illegal,
  output logic                 ex_halt
);

  opcode_t      opcode;
  alu_op_t      alu_op;
  fu_type_t     fu_type;
  src_a_sel_t   source_a_sel;
  src_b_sel_t   source_b_sel;
  w_src_t       w_src;
  branch_type_t branch_type;
  load_type_t   load_type;
  logic         imm_shamt_sel;
  logic         wen;
  logic         jump;
  logic         j_sel;
  logic         branch;
  logic         dren;
  logic         dwen;
  logic         ifence;
  logic         halt_instr;
  logic         illegal;
  logic         fence_pulse;
  word_t        imm_i_ext;
  word_t        imm_s_ext;
  word_t        imm_b_ext;
  word_t        imm_u;
  word_t        imm_j_ext;
  word_t        imm_or_shamt;
  word_t        port_a;
  word_t        port_b;
  word_t        wdata;
  word_t        j_base;
  word_t        j_offset;

  control_unit cu (
    .instr         (instr),
    .opcode        (opcode),
    .reg_rs1       (rs1),
    .reg_rs2       (rs2),
    .reg_rd        (rd_decode),
    .alu_op        (alu_op),
    .fu_type       (fu_type),
    .source_a_sel  (source_a_sel),
    .source_b_sel  (source_b_sel),
    .imm_shamt_sel (imm_shamt_sel),
    .w_src         (w_src),
    .wen           (wen),
    .jump          (jump),
    .j_sel         (j_sel),
    .branch        (branch),
    .branch_type   (branch_type),
    .dren          (dren),
    .dwen          (dwen),
    .load_type     (load_type),
    .ifence        (ifence),
    .halt_instr    (halt_instr),
    .illegal       (illegal)
  );

  imm_gen immgen (
    .instr         (instr),
    .imm_shamt_sel (imm_shamt_sel),
    .imm_i_ext     (imm_i_ext),
    .imm_s_ext     (imm_s_ext),
    .imm_b_ext     (imm_b_ext),
    .imm_u         (imm_u),
    .imm_j_ext     (imm_j_ext),
    .imm_or_shamt  (imm_or_shamt)
  );

  operand_select opsel (
    .source_a_sel (source_a_sel),
    .source_b_sel (source_b_sel),
    .w_src        (w_src),
    .j_sel        (j_sel),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .pc           (pc),
    .pc4          (pc4),
    .imm_s_ext    (imm_s_ext),
    .imm_or_shamt (imm_or_shamt),
    .imm_u        (imm_u),
    .imm_i_ext    (imm_i_ext),
    .imm_j_ext    (imm_j_ext),
    .port_a       (port_a),
    .port_b       (port_b),
    .wdata        (wdata),
    .j_base       (j_base),
    .j_offset     (j_offset)
  );

  fence_unit fence (
    .CLK         (CLK),
    .nRST        (nRST),
    .ifence      (ifence),
    .pc_en       (pc_en),
    .iflush_done (iflush_done),
    .dflush_done (dflush_done),
    .fence_pulse (fence_pulse),
    .iflushed    (iflushed),
    .dflushed    (dflushed)
  );

  // fence.i writes back dirty data and invalidates the icache together
  assign icache_flush = fence_pulse;
  assign dcache_flush = fence_pulse;

  // mark rd pending in the register file
  assign rf_rden = wen & ~branch;

  // fences take no completion buffer slot
  assign alloc_ena = ~stall_fetch_decode & (opcode != MISCMEM);

  decode_execute_latch #(
    .ROB_IDX_W (ROB_IDX_W)
  ) de_latch (
    .CLK                  (CLK),
    .nRST                 (nRST),
    .halt                 (halt),
    .stall_ex             (stall_ex),
    .stall_fetch_decode   (stall_fetch_decode),
    .decode_execute_flush (decode_execute_flush),
    .cur_tail             (cur_tail),
    .fu_type              (fu_type),
    .alu_op               (alu_op),
    .port_a               (port_a),
    .port_b               (port_b),
    .pc                   (pc),
    .pc4                  (pc4),
    .imm_b_ext            (imm_b_ext),
    .wdata                (wdata),
    .reg_rd               (rd_decode),
    .wen                  (wen),
    .jump                 (jump),
    .j_base               (j_base),
    .j_offset             (j_offset),
    .branch               (branch),
    .branch_type          (branch_type),
    .dren                 (dren),
    .dwen                 (dwen),
    .load_type            (load_type),
    .rs2_data             (rs2_data),
    .illegal              (illegal),
    .halt_instr           (halt_instr),
    .ex_fu_type           (ex_fu_type),
    .ex_alu_op            (ex_alu_op),
    .ex_port_a            (ex_port_a),
    .ex_port_b            (ex_port_b),
    .ex_pc                (ex_pc),
    .ex_pc4               (ex_pc4),
    .ex_immediate         (ex_immediate),
    .ex_wdata             (ex_wdata),
    .ex_rd                (ex_rd),
    .ex_wen               (ex_wen),
    .ex_jump_instr        (ex_jump_instr),
    .ex_j_base            (ex_j_base),
    .ex_j_offset          (ex_j_offset),
    .ex_branch_instr      (ex_branch_instr),
    .ex_branch_type       (ex_branch_type),
    .ex_dren              (ex_dren),
    .ex_dwen              (ex_dwen),
    .ex_load_type         (ex_load_type),
    .ex_store_data        (ex_store_data),
    .ex_rob_index         (ex_rob_index),
    .ex_illegal           (ex_illegal),
    .ex_halt              (ex_halt)
  );

endmodule

`default_nettype wire

// ==== decode_execute_latch.sv ====
`default_nettype none

module decode_execute_latch import decode_pkg::*; #(
  parameter int ROB_IDX_W = decode_pkg::ROB_IDX_W
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 halt,
  input  logic                 stall_ex,
  input  logic                 stall_fetch_decode,
  input  logic                 decode_execute_flush,
  input  logic [ROB_IDX_W-1:0] cur_tail,
  input  fu_type_t             fu_type,
  input  alu_op_t              alu_op,
  input  word_t                port_a,
  input  word_t                port_b,
  input  word_t                pc,
  input  word_t                pc4,
  input  word_t                imm_b_ext,
  input  word_t                wdata,
  input  reg_idx_t             reg_rd,
  input  logic                 wen,
  input  logic                 jump,
  input  word_t                j_base,
  input  word_t                j_offset,
  input  logic                 branch,
  input  branch_type_t         branch_type,
  input  logic                 dren,
  input  logic                 dwen,
  input  load_type_t           load_type,
  input  word_t                rs2_data,
  input  logic                 illegal,
  input  logic                 halt_instr,
  output fu_type_t             ex_fu_type,
  output alu_op_t              ex_alu_op,
  output word_t                ex_port_a,
  output word_t                ex_port_b,
  output word_t                ex_pc,
  output word_t                ex_pc4,
  output word_t                ex_immediate,
  output word_t                ex_wdata,
  output reg_idx_t             ex_rd,
  output logic                 ex_wen,
  output logic                 ex_jump_instr,
  output word_t                ex_j_base,
  output word_t                ex_j_offset,
  output logic                 ex_branch_instr,
  output branch_type_t         ex_branch_type,
  output logic                 ex_dren,
  output logic                 ex_dwen,
  output load_type_t           ex_load_type,
  output word_t                ex_store_data,
  output logic [ROB_IDX_W-1:0] ex_rob_index,
  output logic                 ex_illegal,
  output logic                 ex_halt
);

  logic bubble;

  // flush, bubble when fetch stalls but execute drains, or halt
  assign bubble = decode_execute_flush | (stall_fetch_decode & ~stall_ex) | halt;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST || bubble) begin
      ex_fu_type      <= ARITH_S;
      ex_alu_op       <= ALU_ADD;
      ex_port_a       <= '0;
      ex_port_b       <= '0;
      ex_pc           <= '0;
      ex_pc4          <= '0;
      ex_immediate    <= '0;
      ex_wdata        <= '0;
      ex_rd           <= '0;
      ex_wen          <= 1'b0;
      ex_jump_instr   <= 1'b0;
      ex_j_base       <= '0;
      ex_j_offset     <= '0;
      ex_branch_instr <= 1'b0;
      ex_branch_type  <= '0;
      ex_dren         <= 1'b0;
      ex_dwen         <= 1'b0;
      ex_load_type    <= '0;
      ex_store_data   <= '0;
      ex_rob_index    <= '0;
      ex_illegal      <= 1'b0;
      ex_halt         <= 1'b0;
    end else if (!stall_ex) begin
      ex_fu_type      <= fu_type;
      ex_alu_op       <= alu_op;
      ex_port_a       <= port_a;
      ex_port_b       <= port_b;
      ex_pc           <= pc;
      ex_pc4          <= pc4;
      // branch offset, the target is computed in execute
      ex_immediate    <= imm_b_ext;
      ex_wdata        <= wdata;
      ex_rd           <= reg_rd;
      ex_wen          <= wen;
      ex_jump_instr   <= jump;
      ex_j_base       <= j_base;
      ex_j_offset     <= j_offset;
      ex_branch_instr <= branch;
      ex_branch_type  <= branch_type;
      ex_dren         <= dren;
      ex_dwen         <= dwen;
      ex_load_type    <= load_type;
      ex_store_data   <= (fu_type == LOADSTORE_S) ? rs2_data : '0;
      // completion buffer slot allocated this cycle
      ex_rob_index    <= cur_tail;
      ex_illegal      <= illegal;
      ex_halt         <= halt_instr;
    end
  end

endmodule

`default_nettype wire

// ==== fence_unit.sv ====
`default_nettype none

module fence_unit (
  input  logic CLK,
  input  logic nRST,
  input  logic ifence,
  input  logic pc_en,
  input  logic iflush_done,
  input  logic dflush_done,
  output logic fence_pulse,
  output logic iflushed,
  output logic dflushed
);

  logic ifence_q;

  // only advances with the pc, so a stalled fence keeps its pulse
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ifence_q <= 1'b0;
    end else if (pc_en) begin
      ifence_q <= ifence;
    end
  end

  // rising edge of ifence, back to back fences give one pulse
  assign fence_pulse = ifence & ~ifence_q;

  // both caches start out clean
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      iflushed <= 1'b1;
      dflushed <= 1'b1;
    end else if (fence_pulse) begin
      iflushed <= 1'b0;
      dflushed <= 1'b0;
    end else begin
      if (iflush_done && pc_en) begin
        iflushed <= 1'b1;
      end
      if (dflush_done && pc_en) begin
        dflushed <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== operand_select.sv ====
`default_nettype none

module operand_select import decode_pkg::*; (
  input  src_a_sel_t source_a_sel,
  input  src_b_sel_t source_b_sel,
  input  w_src_t     w_src,
  input  logic       j_sel,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  input  word_t      pc,
  input  word_t      pc4,
  input  word_t      imm_s_ext,
  input  word_t      imm_or_shamt,
  input  word_t      imm_u,
  input  word_t      imm_i_ext,
  input  word_t      imm_j_ext,
  output word_t      port_a,
  output word_t      port_b,
  output word_t      wdata,
  output word_t      j_base,
  output word_t      j_offset
);

  always_comb begin
    case (source_a_sel)
      SRC_A_RS1:   port_a = rs1_data;
      SRC_A_IMM_S: port_a = imm_s_ext;
      SRC_A_PC:    port_a = pc;
      default:     port_a = '0;
    endcase
  end

  always_comb begin
    case (source_b_sel)
      SRC_B_RS1:          port_b = rs1_data;
      SRC_B_RS2:          port_b = rs2_data;
      SRC_B_IMM_OR_SHAMT: port_b = imm_or_shamt;
      default:            port_b = imm_u;
    endcase
  end

  // alu results are written back from execute, not from here
  always_comb begin
    case (w_src)
      W_PC4:   wdata = pc4;
      W_IMM_U: wdata = imm_u;
      default: wdata = '0;
    endcase
  end

  // jal is pc relative, jalr is register relative
  assign j_base   = j_sel ? pc : port_a;
  assign j_offset = j_sel ? imm_j_ext : imm_i_ext;

endmodule

`default_nettype wire

// ==== imm_gen.sv ====
`default_nettype none

module imm_gen import decode_pkg::*; (
  input  word_t instr,
  input  logic  imm_shamt_sel,
  output word_t imm_i_ext,
  output word_t imm_s_ext,
  output word_t imm_b_ext,
  output word_t imm_u,
  output word_t imm_j_ext,
  output word_t imm_or_shamt
);

  logic sign;

  assign sign = instr[31];

  assign imm_i_ext = {{20{sign}}, instr[31:20]};
  assign imm_s_ext = {{20{sign}}, instr[31:25], instr[11:7]};

  // branch and jump offsets are in half-words, bit 0 always zero
  assign imm_b_ext = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j_ext = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};

  assign imm_u = {instr[31:12], 12'h000};

  // shift amount replaces the i immediate for slli/srli/srai
  assign imm_or_shamt = imm_shamt_sel ? {27'd0, instr[24:20]} : imm_i_ext;

endmodule

`default_nettype wire

// ==== control_unit.sv ====
`default_nettype none

module control_unit import decode_pkg::*; (
  input  word_t        instr,
  output opcode_t      opcode,
  output reg_idx_t     reg_rs1,
  output reg_idx_t     reg_rs2,
  output reg_idx_t     reg_rd,
  output alu_op_t      alu_op,
  output fu_type_t     fu_type,
  output src_a_sel_t   source_a_sel,
  output src_b_sel_t   source_b_sel,
  output logic         imm_shamt_sel,
  output w_src_t       w_src,
  output logic         wen,
  output logic         jump,
  output logic         j_sel,
  output logic         branch,
  output branch_type_t branch_type,
  output logic         dren,
  output logic         dwen,
  output load_type_t   load_type,
  output logic         ifence,
  output logic         halt_instr,
  output logic         illegal
);

  logic [2:0] funct3;
  logic       alt_op;
  alu_op_t    arith_op;

  assign opcode  = opcode_t'(instr[6:0]);
  assign reg_rd  = instr[11:7];
  assign funct3  = instr[14:12];
  assign reg_rs1 = instr[19:15];
  assign reg_rs2 = instr[24:20];
  // funct7 bit 5 picks sub and sra
  assign alt_op  = instr[30];

  assign branch_type = funct3;
  assign load_type   = funct3;
  assign halt_instr  = (instr == HALT_INSTR);

  // shared alu decode for reg-reg and reg-imm forms
  always_comb begin
    case (funct3)
      3'b000:  arith_op = alt_op ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = alt_op ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    alu_op        = ALU_ADD;
    fu_type       = ARITH_S;
    source_a_sel  = SRC_A_RS1;
    source_b_sel  = SRC_B_RS2;
    imm_shamt_sel = 1'b0;
    w_src         = W_ALU;
    wen           = 1'b0;
    jump          = 1'b0;
    j_sel         = 1'b0;
    branch        = 1'b0;
    dren          = 1'b0;
    dwen          = 1'b0;
    ifence        = 1'b0;
    illegal       = 1'b0;

    case (opcode)
      REGREG: begin
        alu_op = arith_op;
        wen    = 1'b1;
      end
      IMMED: begin
        // no subtract form for immediates
        alu_op        = (funct3 == 3'b000) ? ALU_ADD : arith_op;
        source_b_sel  = SRC_B_IMM_OR_SHAMT;
        imm_shamt_sel = (funct3 == 3'b001) || (funct3 == 3'b101);
        wen           = 1'b1;
      end
      LUI: begin
        source_a_sel = SRC_A_ZERO;
        source_b_sel = SRC_B_IMM_U;
        w_src        = W_IMM_U;
        wen          = 1'b1;
      end
      AUIPC: begin
        // pc + upper immediate, summed in execute
        source_a_sel = SRC_A_PC;
        source_b_sel = SRC_B_IMM_U;
        wen          = 1'b1;
      end
      JAL: begin
        jump  = 1'b1;
        j_sel = 1'b1;
        w_src = W_PC4;
        wen   = 1'b1;
      end
      JALR: begin
        jump  = 1'b1;
        w_src = W_PC4;
        wen   = 1'b1;
      end
      BRANCH: begin
        alu_op = ALU_SUB;
        branch = 1'b1;
      end
      LOAD: begin
        fu_type      = LOADSTORE_S;
        source_b_sel = SRC_B_IMM_OR_SHAMT;
        dren         = 1'b1;
        wen          = 1'b1;
      end
      STORE: begin
        fu_type      = LOADSTORE_S;
        source_a_sel = SRC_A_IMM_S;
        source_b_sel = SRC_B_RS1;
        dwen         = 1'b1;
      end
      MISCMEM: begin
        // plain fence is a nop here, only fence.i matters
        ifence = (funct3 == 3'b001);
      end
      default: begin
        illegal = ~halt_instr;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== decode_pkg.sv ====
`default_nettype none

package decode_pkg;

  // completion buffer depth is 2**ROB_IDX_W entries
  parameter int ROB_IDX_W = 4;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  // both carry funct3 unchanged
  typedef logic [2:0] branch_type_t;
  typedef logic [2:0] load_type_t;

  // rv32i major opcodes handled by this stage
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    MISCMEM = 7'b0001111
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  typedef enum logic {
    ARITH_S     = 1'b0,
    LOADSTORE_S = 1'b1
  } fu_type_t;

  typedef enum logic [1:0] {
    SRC_A_RS1, SRC_A_IMM_S, SRC_A_PC, SRC_A_ZERO
  } src_a_sel_t;

  typedef enum logic [1:0] {
    SRC_B_RS1, SRC_B_RS2, SRC_B_IMM_OR_SHAMT, SRC_B_IMM_U
  } src_b_sel_t;

  typedef enum logic [1:0] {
    W_ALU, W_PC4, W_IMM_U
  } w_src_t;

  // all ones never decodes as a real instruction
  localparam word_t HALT_INSTR = 32'hffff_ffff;

endpackage

`default_nettype wire
